/* hw/mcu_cfg_pkg.sv */
// ************************************************
// mini MCU configuration
// address map, bus widths, AO register offsets
// ************************************************
`default_nettype none

package mcu_cfg_pkg;

  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;

  // default RAM geometry, overridable at the top level
  localparam int unsigned NUM_BANKS  = 2;
  localparam int unsigned BANK_WORDS = 256;

  localparam logic [ADDR_W-1:0] RAM_BASE = 32'h0000_0000;
  localparam logic [ADDR_W-1:0] AO_BASE  = 32'h2000_0000;
  localparam int unsigned       AO_SIZE  = 256;

  // returned on reads that hit no target
  localparam logic [DATA_W-1:0] ERR_RDATA = 32'hBADA_CCE5;

  localparam int unsigned NUM_GPIO = 8;

  typedef enum logic [7:0] {
    AO_EXIT        = 8'h00,
    AO_GPIO_OUT    = 8'h04,
    AO_GPIO_OE     = 8'h08,
    AO_GPIO_IN     = 8'h0C,
    AO_INTR_EN     = 8'h10,
    AO_INTR_STATUS = 8'h14,
    AO_PWR_REQ     = 8'h18,
    AO_PWR_STATUS  = 8'h1C
  } ao_reg_e;

endpackage

`default_nettype wire

/* hw/pwr_pkg.sv */
// ************************************************
// power sequencing types
// ************************************************
`default_nettype none

package pwr_pkg;

  typedef enum logic [2:0] {
    PWR_ON,
    PWR_ISO,
    PWR_SWITCH_OFF,
    PWR_OFF,
    PWR_SWITCH_ON,
    PWR_DEISO
  } pwr_state_e;

  // control lines of one bank, switch and iso are active low
  typedef struct packed {
    logic switch_n;
    logic iso_n;
    logic on;
  } pwr_ctrl_t;

endpackage

`default_nettype wire

/* hw/obi_if.sv */
// ************************************************
// request/grant/rvalid bus between fabric blocks
// ************************************************
`timescale 1ns/1ps
`default_nettype none

interface obi_if;

  logic                           req;
  logic                           we;
  logic [mcu_cfg_pkg::ADDR_W-1:0] addr;
  logic [mcu_cfg_pkg::DATA_W-1:0] wdata;
  logic                           gnt;
  logic                           rvalid;
  logic [mcu_cfg_pkg::DATA_W-1:0] rdata;

  modport manager (
    output req, we, addr, wdata,
    input  gnt, rvalid, rdata
  );

  modport subordinate (
    input  req, we, addr, wdata,
    output gnt, rvalid, rdata
  );

endinterface

`default_nettype wire

/* hw/system_bus.sv */
// ************************************************
// system bus
// decodes host requests to RAM banks and AO block
// ************************************************
`timescale 1ns/1ps
`default_nettype none

module system_bus #(
  parameter int unsigned NUM_BANKS  = mcu_cfg_pkg::NUM_BANKS,
  parameter int unsigned BANK_WORDS = mcu_cfg_pkg::BANK_WORDS
) (
  input  logic       clk_i,
  input  logic       arst_n_i,
  obi_if.subordinate host,
  obi_if.manager     bank [NUM_BANKS],
  obi_if.manager     ao
);

  localparam int unsigned OFFS_W = $clog2(BANK_WORDS * 4);
  localparam int unsigned TGT_W  = $clog2(NUM_BANKS + 2);
  localparam logic [TGT_W-1:0] TGT_AO  = TGT_W'(NUM_BANKS);
  localparam logic [TGT_W-1:0] TGT_ERR = TGT_W'(NUM_BANKS + 1);
  localparam logic [mcu_cfg_pkg::ADDR_W-1:0] RAM_SPAN = NUM_BANKS * BANK_WORDS * 4;
  localparam logic [mcu_cfg_pkg::ADDR_W-1:0] AO_SPAN  = mcu_cfg_pkg::AO_SIZE;

  logic [mcu_cfg_pkg::ADDR_W-1:0] ram_off;
  logic [mcu_cfg_pkg::ADDR_W-1:0] ao_off;
  logic [TGT_W-1:0]               tgt;
  logic [TGT_W-1:0]               rsp_tgt_q;
  logic                           err_valid_q;
  logic                           xfer;
  logic [NUM_BANKS-1:0]           bank_gnt;
  logic [NUM_BANKS-1:0]           bank_rvalid;
  logic [mcu_cfg_pkg::DATA_W-1:0] bank_rdata [NUM_BANKS];

  // offsets wrap below the base, so one compare per window is enough
  assign ram_off = host.addr - mcu_cfg_pkg::RAM_BASE;
  assign ao_off  = host.addr - mcu_cfg_pkg::AO_BASE;

  always_comb begin
    if (ram_off < RAM_SPAN) begin
      tgt = TGT_W'(ram_off >> OFFS_W);
    end else if (ao_off < AO_SPAN) begin
      tgt = TGT_AO;
    end else begin
      tgt = TGT_ERR;
    end
  end

  for (genvar i = 0; i < NUM_BANKS; i++) begin : gen_bank_port
    assign bank[i].req    = host.req && (tgt == TGT_W'(i));
    assign bank[i].we     = host.we;
    assign bank[i].addr   = ram_off;
    assign bank[i].wdata  = host.wdata;
    assign bank_gnt[i]    = bank[i].gnt;
    assign bank_rvalid[i] = bank[i].rvalid;
    assign bank_rdata[i]  = bank[i].rdata;
  end

  assign ao.req   = host.req && (tgt == TGT_AO);
  assign ao.we    = host.we;
  assign ao.addr  = ao_off;
  assign ao.wdata = host.wdata;

  // unmapped requests are answered here
  always_comb begin
    host.gnt = 1'b0;
    if (tgt == TGT_ERR) begin
      host.gnt = host.req;
    end else if (tgt == TGT_AO) begin
      host.gnt = ao.gnt;
    end else begin
      for (int i = 0; i < NUM_BANKS; i++) begin
        if (tgt == TGT_W'(i)) begin
          host.gnt = bank_gnt[i];
        end
      end
    end
  end

  assign xfer = host.req && host.gnt;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rsp_tgt_q   <= '0;
      err_valid_q <= 1'b0;
    end else begin
      err_valid_q <= xfer && (tgt == TGT_ERR);
      if (xfer) begin
        rsp_tgt_q <= tgt;
      end
    end
  end

  // response comes from whoever took the last transfer
  always_comb begin
    host.rvalid = err_valid_q;
    host.rdata  = mcu_cfg_pkg::ERR_RDATA;
    if (rsp_tgt_q == TGT_AO) begin
      host.rvalid = ao.rvalid;
      host.rdata  = ao.rdata;
    end else begin
      for (int i = 0; i < NUM_BANKS; i++) begin
        if (rsp_tgt_q == TGT_W'(i)) begin
          host.rvalid = bank_rvalid[i];
          host.rdata  = bank_rdata[i];
        end
      end
    end
  end

endmodule

`default_nettype wire

/* hw/ram_bank.sv */
// ************************************************
// power-gated SRAM bank, one word per address
// ************************************************
`timescale 1ns/1ps
`default_nettype none

module ram_bank #(
  parameter int unsigned BANK_WORDS = mcu_cfg_pkg::BANK_WORDS
) (
  input  logic       clk_i,
  input  logic       arst_n_i,
  obi_if.subordinate bus,
  input  logic       bank_on_i
);

  localparam int unsigned IDX_W = $clog2(BANK_WORDS);

  logic [mcu_cfg_pkg::DATA_W-1:0] mem [BANK_WORDS];
  logic [IDX_W-1:0]               word_idx;
  logic                           xfer;
  logic                           rvalid_q;
  logic [mcu_cfg_pkg::DATA_W-1:0] rdata_q;

  // no grant while the bank is powered down or isolated
  assign bus.gnt  = bus.req && bank_on_i;
  assign xfer     = bus.req && bank_on_i;
  assign word_idx = bus.addr[IDX_W+1:2];

  always_ff @(posedge clk_i) begin
    if (xfer) begin
      if (bus.we) begin
        mem[word_idx] <= bus.wdata;
      end else begin
        rdata_q <= mem[word_idx];
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= xfer;
    end
  end

  assign bus.rvalid = rvalid_q;
  assign bus.rdata  = rdata_q;

endmodule

`default_nettype wire

/* hw/power_manager.sv */
// ************************************************
// power manager
// sequences isolation and switch for each bank
// ************************************************
`timescale 1ns/1ps
`default_nettype none

module power_manager #(
  parameter int unsigned NUM_BANKS = mcu_cfg_pkg::NUM_BANKS
) (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic [NUM_BANKS-1:0] pwr_req_i,
  input  logic [NUM_BANKS-1:0] bank_switch_ack_ni,
  output logic [NUM_BANKS-1:0] bank_switch_no,
  output logic [NUM_BANKS-1:0] bank_iso_no,
  output logic [NUM_BANKS-1:0] bank_on_o
);

  for (genvar i = 0; i < NUM_BANKS; i++) begin : gen_seq
    pwr_pkg::pwr_state_e state_q;
    pwr_pkg::pwr_state_e state_d;
    pwr_pkg::pwr_ctrl_t  ctrl;

    always_comb begin
      state_d = state_q;
      case (state_q)
        pwr_pkg::PWR_ON: begin
          if (!pwr_req_i[i]) begin
            state_d = pwr_pkg::PWR_ISO;
          end
        end
        pwr_pkg::PWR_ISO: begin
          state_d = pwr_pkg::PWR_SWITCH_OFF;
        end
        // ack is active low, high means the rail is down
        pwr_pkg::PWR_SWITCH_OFF: begin
          if (bank_switch_ack_ni[i]) begin
            state_d = pwr_pkg::PWR_OFF;
          end
        end
        pwr_pkg::PWR_OFF: begin
          if (pwr_req_i[i]) begin
            state_d = pwr_pkg::PWR_SWITCH_ON;
          end
        end
        pwr_pkg::PWR_SWITCH_ON: begin
          if (!bank_switch_ack_ni[i]) begin
            state_d = pwr_pkg::PWR_DEISO;
          end
        end
        pwr_pkg::PWR_DEISO: begin
          state_d = pwr_pkg::PWR_ON;
        end
        default: begin
          state_d = pwr_pkg::PWR_ISO;
        end
      endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        state_q <= pwr_pkg::PWR_ON;
      end else begin
        state_q <= state_d;
      end
    end

    // isolation stays on around every switch transition
    always_comb begin
      ctrl = '{switch_n: 1'b0, iso_n: 1'b0, on: 1'b0};
      case (state_q)
        pwr_pkg::PWR_ON:         ctrl = '{switch_n: 1'b0, iso_n: 1'b1, on: 1'b1};
        pwr_pkg::PWR_SWITCH_OFF: ctrl = '{switch_n: 1'b1, iso_n: 1'b0, on: 1'b0};
        pwr_pkg::PWR_OFF:        ctrl = '{switch_n: 1'b1, iso_n: 1'b0, on: 1'b0};
        pwr_pkg::PWR_DEISO:      ctrl = '{switch_n: 1'b0, iso_n: 1'b1, on: 1'b0};
        default:                 ctrl = '{switch_n: 1'b0, iso_n: 1'b0, on: 1'b0};
      endcase
    end

    assign bank_switch_no[i] = ctrl.switch_n;
    assign bank_iso_no[i]    = ctrl.iso_n;
    assign bank_on_o[i]      = ctrl.on;
  end

endmodule

`default_nettype wire

/* hw/ao_periph.sv */
// ************************************************
// always-on peripheral block
// exit value, GPIO with interrupts, bank power
// ************************************************
`timescale 1ns/1ps
`default_nettype none

module ao_periph #(
  parameter int unsigned NUM_BANKS = mcu_cfg_pkg::NUM_BANKS
) (
  input  logic                             clk_i,
  input  logic                             arst_n_i,
  obi_if.subordinate                       bus,
  input  logic [mcu_cfg_pkg::NUM_GPIO-1:0] gpio_i,
  output logic [mcu_cfg_pkg::NUM_GPIO-1:0] gpio_o,
  output logic [mcu_cfg_pkg::NUM_GPIO-1:0] gpio_oe_o,
  output logic                             irq_o,
  output logic                             exit_valid_o,
  output logic [mcu_cfg_pkg::DATA_W-1:0]   exit_value_o,
  output logic [NUM_BANKS-1:0]             pwr_req_o,
  input  logic [NUM_BANKS-1:0]             bank_on_i
);

  mcu_cfg_pkg::ao_reg_e             reg_off;
  logic                             xfer;
  logic                             wr;
  logic                             rvalid_q;
  logic [mcu_cfg_pkg::DATA_W-1:0]   rdata_q;
  logic [mcu_cfg_pkg::DATA_W-1:0]   rdata_d;
  logic [mcu_cfg_pkg::DATA_W-1:0]   exit_value_q;
  logic                             exit_valid_q;
  logic [mcu_cfg_pkg::NUM_GPIO-1:0] gpio_out_q;
  logic [mcu_cfg_pkg::NUM_GPIO-1:0] gpio_oe_q;
  logic [mcu_cfg_pkg::NUM_GPIO-1:0] intr_en_q;
  logic [mcu_cfg_pkg::NUM_GPIO-1:0] intr_status_q;
  logic [mcu_cfg_pkg::NUM_GPIO-1:0] intr_clr;
  logic [mcu_cfg_pkg::NUM_GPIO-1:0] gpio_sync1_q;
  logic [mcu_cfg_pkg::NUM_GPIO-1:0] gpio_sync2_q;
  logic [mcu_cfg_pkg::NUM_GPIO-1:0] gpio_prev_q;
  logic [mcu_cfg_pkg::NUM_GPIO-1:0] gpio_rise;
  logic [NUM_BANKS-1:0]             pwr_req_q;

  assign bus.gnt  = bus.req;
  assign xfer     = bus.req;
  assign wr       = xfer && bus.we;
  assign reg_off  = mcu_cfg_pkg::ao_reg_e'(bus.addr[7:0]);

  assign gpio_rise = gpio_sync2_q & ~gpio_prev_q;
  assign intr_clr  = (wr && reg_off == mcu_cfg_pkg::AO_INTR_STATUS) ?
                     bus.wdata[mcu_cfg_pkg::NUM_GPIO-1:0] : '0;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      exit_value_q  <= '0;
      exit_valid_q  <= 1'b0;
      gpio_out_q    <= '0;
      gpio_oe_q     <= '0;
      intr_en_q     <= '0;
      intr_status_q <= '0;
      gpio_sync1_q  <= '0;
      gpio_sync2_q  <= '0;
      gpio_prev_q   <= '0;
      pwr_req_q     <= '1;
      rvalid_q      <= 1'b0;
    end else begin
      gpio_sync1_q  <= gpio_i;
      gpio_sync2_q  <= gpio_sync1_q;
      gpio_prev_q   <= gpio_sync2_q;
      // a new edge wins over a clear in the same cycle
      intr_status_q <= (intr_status_q & ~intr_clr) | gpio_rise;
      rvalid_q      <= xfer;
      if (wr) begin
        case (reg_off)
          mcu_cfg_pkg::AO_EXIT: begin
            exit_value_q <= bus.wdata;
            exit_valid_q <= 1'b1;
          end
          mcu_cfg_pkg::AO_GPIO_OUT: gpio_out_q <= bus.wdata[mcu_cfg_pkg::NUM_GPIO-1:0];
          mcu_cfg_pkg::AO_GPIO_OE:  gpio_oe_q  <= bus.wdata[mcu_cfg_pkg::NUM_GPIO-1:0];
          mcu_cfg_pkg::AO_INTR_EN:  intr_en_q  <= bus.wdata[mcu_cfg_pkg::NUM_GPIO-1:0];
          mcu_cfg_pkg::AO_PWR_REQ:  pwr_req_q  <= bus.wdata[NUM_BANKS-1:0];
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    rdata_d = '0;
    case (reg_off)
      mcu_cfg_pkg::AO_EXIT:        rdata_d = exit_value_q;
      mcu_cfg_pkg::AO_GPIO_OUT:    rdata_d[mcu_cfg_pkg::NUM_GPIO-1:0] = gpio_out_q;
      mcu_cfg_pkg::AO_GPIO_OE:     rdata_d[mcu_cfg_pkg::NUM_GPIO-1:0] = gpio_oe_q;
      mcu_cfg_pkg::AO_GPIO_IN:     rdata_d[mcu_cfg_pkg::NUM_GPIO-1:0] = gpio_sync2_q;
      mcu_cfg_pkg::AO_INTR_EN:     rdata_d[mcu_cfg_pkg::NUM_GPIO-1:0] = intr_en_q;
      mcu_cfg_pkg::AO_INTR_STATUS: rdata_d[mcu_cfg_pkg::NUM_GPIO-1:0] = intr_status_q;
      mcu_cfg_pkg::AO_PWR_REQ:     rdata_d[NUM_BANKS-1:0] = pwr_req_q;
      mcu_cfg_pkg::AO_PWR_STATUS:  rdata_d[NUM_BANKS-1:0] = bank_on_i;
      default:                     rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (xfer && !bus.we) begin
      rdata_q <= rdata_d;
    end
  end

  assign bus.rvalid   = rvalid_q;
  assign bus.rdata    = rdata_q;
  assign gpio_o       = gpio_out_q;
  assign gpio_oe_o    = gpio_oe_q;
  assign irq_o        = |(intr_status_q & intr_en_q);
  assign exit_valid_o = exit_valid_q;
  assign exit_value_o = exit_value_q;
  assign pwr_req_o    = pwr_req_q;

endmodule

`default_nettype wire

/* hw/mini_mcu_top.sv */
// ************************************************
// mini MCU fabric top level
// ************************************************
`timescale 1ns/1ps
`default_nettype none

module mini_mcu_top #(
  parameter int unsigned NUM_BANKS  = mcu_cfg_pkg::NUM_BANKS,
  parameter int unsigned BANK_WORDS = mcu_cfg_pkg::BANK_WORDS
) (
  input  logic                             clk_i,
  input  logic                             arst_n_i,
  input  logic                             bus_req_i,
  input  logic                             bus_we_i,
  input  logic [mcu_cfg_pkg::ADDR_W-1:0]   bus_addr_i,
  input  logic [mcu_cfg_pkg::DATA_W-1:0]   bus_wdata_i,
  output logic                             bus_gnt_o,
  output logic                             bus_rvalid_o,
  output logic [mcu_cfg_pkg::DATA_W-1:0]   bus_rdata_o,
  input  logic [mcu_cfg_pkg::NUM_GPIO-1:0] gpio_i,
  output logic [mcu_cfg_pkg::NUM_GPIO-1:0] gpio_o,
  output logic [mcu_cfg_pkg::NUM_GPIO-1:0] gpio_oe_o,
  output logic                             irq_o,
  output logic                             exit_valid_o,
  output logic [mcu_cfg_pkg::DATA_W-1:0]   exit_value_o,
  output logic [NUM_BANKS-1:0]             bank_switch_no,
  input  logic [NUM_BANKS-1:0]             bank_switch_ack_ni,
  output logic [NUM_BANKS-1:0]             bank_iso_no
);

  obi_if host_bus ();
  obi_if bank_bus [NUM_BANKS] ();
  obi_if ao_bus ();

  logic [NUM_BANKS-1:0] pwr_req;
  logic [NUM_BANKS-1:0] bank_on;

  assign host_bus.req   = bus_req_i;
  assign host_bus.we    = bus_we_i;
  assign host_bus.addr  = bus_addr_i;
  assign host_bus.wdata = bus_wdata_i;
  assign bus_gnt_o      = host_bus.gnt;
  assign bus_rvalid_o   = host_bus.rvalid;
  assign bus_rdata_o    = host_bus.rdata;

  system_bus #(
    .NUM_BANKS (NUM_BANKS),
    .BANK_WORDS(BANK_WORDS)
  ) system_bus_i (
    .clk_i,
    .arst_n_i,
    .host(host_bus),
    .bank(bank_bus),
    .ao  (ao_bus)
  );

  for (genvar i = 0; i < NUM_BANKS; i++) begin : gen_ram_bank
    ram_bank #(
      .BANK_WORDS(BANK_WORDS)
    ) ram_bank_i (
      .clk_i,
      .arst_n_i,
      .bus      (bank_bus[i]),
      .bank_on_i(bank_on[i])
    );
  end

  power_manager #(
    .NUM_BANKS(NUM_BANKS)
  ) power_manager_i (
    .clk_i,
    .arst_n_i,
    .pwr_req_i(pwr_req),
    .bank_switch_ack_ni,
    .bank_switch_no,
    .bank_iso_no,
    .bank_on_o(bank_on)
  );

  ao_periph #(
    .NUM_BANKS(NUM_BANKS)
  ) ao_periph_i (
    .clk_i,
    .arst_n_i,
    .bus(ao_bus),
    .gpio_i,
    .gpio_o,
    .gpio_oe_o,
    .irq_o,
    .exit_valid_o,
    .exit_value_o,
    .pwr_req_o(pwr_req),
    .bank_on_i(bank_on)
  );

endmodule

`default_nettype wire

/* testbench/mini_mcu_checker.sv */
// ************************************************
// bus and power sequencing assertions
// ************************************************
`timescale 1ns/1ps
`default_nettype none

module mini_mcu_checker #(
  parameter int unsigned NUM_BANKS = mcu_cfg_pkg::NUM_BANKS
) (
  input logic                 clk_i,
  input logic                 arst_n_i,
  input logic                 bus_req_i,
  input logic                 bus_gnt_o,
  input logic                 bus_rvalid_o,
  input logic                 exit_valid_o,
  input logic [NUM_BANKS-1:0] bank_switch_no,
  input logic [NUM_BANKS-1:0] bank_iso_no
);

  int unsigned fail_count = 0;

  rvalid_after_xfer: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    bus_rvalid_o |-> $past(bus_req_i && bus_gnt_o))
  else begin
    fail_count++;
    $error("bus_rvalid_o high without a granted request one cycle before");
  end

  // switch open means isolation must be active
  iso_before_switch: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (bank_switch_no & bank_iso_no) == '0)
  else begin
    fail_count++;
    $error("bank switch open while its isolation is inactive");
  end

  exit_valid_sticky: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !$fell(exit_valid_o))
  else begin
    fail_count++;
    $error("exit_valid_o fell outside reset");
  end

endmodule

bind mini_mcu_top mini_mcu_checker #(
  .NUM_BANKS(NUM_BANKS)
) chk (
  .clk_i         (clk_i),
  .arst_n_i      (arst_n_i),
  .bus_req_i     (bus_req_i),
  .bus_gnt_o     (bus_gnt_o),
  .bus_rvalid_o  (bus_rvalid_o),
  .exit_valid_o  (exit_valid_o),
  .bank_switch_no(bank_switch_no),
  .bank_iso_no   (bank_iso_no)
);

`default_nettype wire

/* testbench/tb_mini_mcu.sv */
// ************************************************
// mini MCU fabric testbench
// directed bus, GPIO, power and exit tests
// ************************************************
`timescale 1ns/1ps
`default_nettype none

module tb_mini_mcu;

  localparam int unsigned NB         = mcu_cfg_pkg::NUM_BANKS;
  localparam int unsigned NG         = mcu_cfg_pkg::NUM_GPIO;
  localparam int unsigned DW         = mcu_cfg_pkg::DATA_W;
  localparam int unsigned AW         = mcu_cfg_pkg::ADDR_W;
  localparam int unsigned CLK_NS     = 8;
  localparam int unsigned BANK_BYTES = mcu_cfg_pkg::BANK_WORDS * 4;
  localparam int unsigned RAM_N      = 12;
  localparam logic [31:0] SEED       = 32'h91d8;

  // rough cycle budget of each test
  localparam int unsigned LEN_RESET    = 20;
  localparam int unsigned LEN_RAM      = 100;
  localparam int unsigned LEN_UNMAPPED = 15;
  localparam int unsigned LEN_GPIO     = 40;
  localparam int unsigned LEN_IRQ      = 70;
  localparam int unsigned LEN_POWER    = 140;
  localparam int unsigned LEN_EXIT     = 20;
  localparam int unsigned WATCHDOG_NS  = 2 * CLK_NS * (LEN_RESET + LEN_RAM + LEN_UNMAPPED
                                         + LEN_GPIO + LEN_IRQ + LEN_POWER + LEN_EXIT);

  logic          clk_i              = 1'b0;
  logic          arst_n_i           = 1'b0;
  logic          bus_req_i          = 1'b0;
  logic          bus_we_i           = 1'b0;
  logic [AW-1:0] bus_addr_i         = '0;
  logic [DW-1:0] bus_wdata_i        = '0;
  logic [NG-1:0] gpio_i             = '0;
  logic [NB-1:0] bank_switch_ack_ni = '0;
  logic          bus_gnt_o;
  logic          bus_rvalid_o;
  logic [DW-1:0] bus_rdata_o;
  logic [NG-1:0] gpio_o;
  logic [NG-1:0] gpio_oe_o;
  logic          irq_o;
  logic          exit_valid_o;
  logic [DW-1:0] exit_value_o;
  logic [NB-1:0] bank_switch_no;
  logic [NB-1:0] bank_iso_no;

  logic [NB-1:0] ack_next          = '0;
  int unsigned   ack_wait [NB]     = '{default: 0};

  mini_mcu_top uut (
    .clk_i, .arst_n_i, .bus_req_i, .bus_we_i, .bus_addr_i, .bus_wdata_i,
    .bus_gnt_o, .bus_rvalid_o, .bus_rdata_o, .gpio_i, .gpio_o, .gpio_oe_o,
    .irq_o, .exit_valid_o, .exit_value_o, .bank_switch_no,
    .bank_switch_ack_ni, .bank_iso_no
  );

  always #(CLK_NS / 2) clk_i = ~clk_i;

  // ack follows the switch after 1 to 4 cycles
  always @(negedge clk_i) begin
    for (int b = 0; b < NB; b++) begin
      if (ack_wait[b] == 0 && bank_switch_no[b] != ack_next[b]) begin
        ack_wait[b] = $urandom_range(4, 1);
      end
      if (ack_wait[b] != 0) begin
        ack_wait[b] = ack_wait[b] - 1;
        if (ack_wait[b] == 0) begin
          ack_next[b] = bank_switch_no[b];
        end
      end
    end
  end

  always @(posedge clk_i) begin
    bank_switch_ack_ni <= ack_next;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: tests did not finish within %0d ns", WATCHDOG_NS);
    $display("Verification failed");
    $fatal(1, "watchdog expired");
  end

  function automatic logic [AW-1:0] ram_addr(input int unsigned bank, input int unsigned word);
    return mcu_cfg_pkg::RAM_BASE + AW'(bank * BANK_BYTES + word * 4);
  endfunction

  function automatic logic [AW-1:0] ao_addr(input mcu_cfg_pkg::ao_reg_e off);
    return mcu_cfg_pkg::AO_BASE + AW'(off);
  endfunction

  task automatic check_word(input string name, input logic [DW-1:0] got,
                            input logic [DW-1:0] exp);
    if (got !== exp) begin
      $display("mismatch at %0t ns: %s got 0x%08h expected 0x%08h", $time, name, got, exp);
      $display("Verification failed");
      $fatal(1, "word compare failed");
    end
  endtask

  task automatic check_gpio(input string name, input logic [NG-1:0] got,
                            input logic [NG-1:0] exp);
    if (got !== exp) begin
      $display("mismatch at %0t ns: %s got 0x%02h expected 0x%02h", $time, name, got, exp);
      $display("Verification failed");
      $fatal(1, "gpio compare failed");
    end
  endtask

  task automatic check_banks(input string name, input logic [NB-1:0] got,
                             input logic [NB-1:0] exp);
    if (got !== exp) begin
      $display("mismatch at %0t ns: %s got %b expected %b", $time, name, got, exp);
      $display("Verification failed");
      $fatal(1, "bank vector compare failed");
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("mismatch at %0t ns: %s got %b expected %b", $time, name, got, exp);
      $display("Verification failed");
      $fatal(1, "flag compare failed");
    end
  endtask

  task automatic fail_now(input string msg);
    $display("error at %0t ns: %s", $time, msg);
    $display("Verification failed");
    $fatal(1, "%s", msg);
  endtask

  // stop at the first assertion failure of the checker
  always @(negedge clk_i) begin
    if (uut.chk.fail_count != 0) begin
      fail_now("a checker assertion failed");
    end
  end

  // single transfer that ends on a falling edge
  task automatic bus_access(input logic we, input logic [AW-1:0] addr,
                            input logic [DW-1:0] wdata, output logic [DW-1:0] rdata,
                            output int unsigned stalls);
    stalls = 0;
    @(posedge clk_i);
    bus_req_i   <= 1'b1;
    bus_we_i    <= we;
    bus_addr_i  <= addr;
    bus_wdata_i <= wdata;
    @(negedge clk_i);
    while (!bus_gnt_o) begin
      stalls++;
      @(negedge clk_i);
    end
    @(posedge clk_i);
    bus_req_i <= 1'b0;
    bus_we_i  <= 1'b0;
    @(negedge clk_i);
    while (!bus_rvalid_o) begin
      @(negedge clk_i);
    end
    rdata = bus_rdata_o;
  endtask

  task automatic bus_write(input logic [AW-1:0] addr, input logic [DW-1:0] data);
    logic [DW-1:0] ignored;
    int unsigned   stalls;
    bus_access(1'b1, addr, data, ignored, stalls);
    if (stalls != 0) begin
      fail_now($sformatf("write to 0x%08h was not granted in the request cycle", addr));
    end
  endtask

  task automatic bus_read(input logic [AW-1:0] addr, output logic [DW-1:0] data);
    int unsigned stalls;
    bus_access(1'b0, addr, '0, data, stalls);
    if (stalls != 0) begin
      fail_now($sformatf("read of 0x%08h was not granted in the request cycle", addr));
    end
  endtask

  task automatic test_reset_state();
    logic [DW-1:0] rdata;
    @(negedge clk_i);
    check_gpio("gpio_o", gpio_o, '0);
    check_gpio("gpio_oe_o", gpio_oe_o, '0);
    check_flag("irq_o", irq_o, 1'b0);
    check_flag("exit_valid_o", exit_valid_o, 1'b0);
    check_word("exit_value_o", exit_value_o, '0);
    check_banks("bank_switch_no", bank_switch_no, '0);
    check_banks("bank_iso_no", bank_iso_no, '1);
    bus_read(ao_addr(mcu_cfg_pkg::AO_PWR_REQ), rdata);
    check_banks("AO_PWR_REQ", rdata[NB-1:0], '1);
  endtask

  task automatic test_ram();
    logic [AW-1:0] addrs [RAM_N];
    logic [DW-1:0] words [RAM_N];
    logic [DW-1:0] rdata;
    // bank edges first and then spread words
    addrs[0] = ram_addr(0, mcu_cfg_pkg::BANK_WORDS - 1);
    addrs[1] = ram_addr(1, 0);
    for (int i = 2; i < RAM_N; i++) begin
      addrs[i] = ram_addr(i % NB, 2 + i * 11);
    end
    for (int i = 0; i < RAM_N; i++) begin
      words[i] = $urandom;
      bus_write(addrs[i], words[i]);
    end
    for (int i = 0; i < RAM_N; i++) begin
      bus_read(addrs[i], rdata);
      check_word($sformatf("bus_rdata_o @0x%08h", addrs[i]), rdata, words[i]);
    end
  endtask

  task automatic test_unmapped();
    logic [DW-1:0] rdata;
    bus_read(32'h1000_0000, rdata);
    check_word("bus_rdata_o unmapped", rdata, mcu_cfg_pkg::ERR_RDATA);
    bus_read(mcu_cfg_pkg::AO_BASE + 32'h100, rdata);
    check_word("bus_rdata_o past AO window", rdata, mcu_cfg_pkg::ERR_RDATA);
  endtask

  task automatic test_gpio();
    logic [DW-1:0] out_w;
    logic [DW-1:0] oe_w;
    logic [NG-1:0] pins;
    logic [DW-1:0] rdata;
    out_w = $urandom;
    oe_w  = $urandom;
    pins  = NG'($urandom);
    bus_write(ao_addr(mcu_cfg_pkg::AO_GPIO_OUT), out_w);
    check_gpio("gpio_o", gpio_o, out_w[NG-1:0]);
    bus_write(ao_addr(mcu_cfg_pkg::AO_GPIO_OE), oe_w);
    check_gpio("gpio_oe_o", gpio_oe_o, oe_w[NG-1:0]);
    @(posedge clk_i);
    gpio_i <= pins;
    repeat (3) @(posedge clk_i);
    bus_read(ao_addr(mcu_cfg_pkg::AO_GPIO_IN), rdata);
    check_gpio("AO_GPIO_IN", rdata[NG-1:0], pins);
  endtask

  task automatic test_irq();
    logic [DW-1:0] rdata;
    @(posedge clk_i);
    gpio_i <= '0;
    repeat (4) @(posedge clk_i);
    bus_write(ao_addr(mcu_cfg_pkg::AO_INTR_STATUS), '1);
    bus_write(ao_addr(mcu_cfg_pkg::AO_INTR_EN), 32'h01);
    check_flag("irq_o", irq_o, 1'b0);
    // enabled pin 0 rises
    @(posedge clk_i);
    gpio_i <= 8'h01;
    repeat (5) @(posedge clk_i);
    bus_read(ao_addr(mcu_cfg_pkg::AO_INTR_STATUS), rdata);
    check_gpio("AO_INTR_STATUS", rdata[NG-1:0], 8'h01);
    check_flag("irq_o", irq_o, 1'b1);
    bus_write(ao_addr(mcu_cfg_pkg::AO_INTR_STATUS), 32'h01);
    check_flag("irq_o", irq_o, 1'b0);
    bus_read(ao_addr(mcu_cfg_pkg::AO_INTR_STATUS), rdata);
    check_gpio("AO_INTR_STATUS", rdata[NG-1:0], 8'h00);
    // disabled pin 5 rises
    @(posedge clk_i);
    gpio_i <= 8'h21;
    repeat (5) @(posedge clk_i);
    bus_read(ao_addr(mcu_cfg_pkg::AO_INTR_STATUS), rdata);
    check_gpio("AO_INTR_STATUS", rdata[NG-1:0], 8'h20);
    check_flag("irq_o", irq_o, 1'b0);
    bus_write(ao_addr(mcu_cfg_pkg::AO_INTR_STATUS), 32'h20);
    bus_read(ao_addr(mcu_cfg_pkg::AO_INTR_STATUS), rdata);
    check_gpio("AO_INTR_STATUS", rdata[NG-1:0], 8'h00);
  endtask

  task automatic test_power();
    logic [NB-1:0] all_on;
    logic [NB-1:0] b1_off;
    logic [DW-1:0] rdata;
    logic [DW-1:0] w0;
    logic [DW-1:0] w1;
    int            iso_cyc;
    int            sw_cyc;
    int unsigned   stalls;
    all_on    = '1;
    b1_off    = '1;
    b1_off[1] = 1'b0;
    iso_cyc   = -1;
    sw_cyc    = -1;
    w0        = $urandom;
    w1        = $urandom;
    bus_read(ao_addr(mcu_cfg_pkg::AO_PWR_STATUS), rdata);
    check_banks("AO_PWR_STATUS", rdata[NB-1:0], all_on);
    bus_write(ao_addr(mcu_cfg_pkg::AO_PWR_REQ), DW'(b1_off));
    for (int c = 0; c < 40; c++) begin
      if (iso_cyc < 0 && !bank_iso_no[1]) begin
        iso_cyc = c;
      end
      if (sw_cyc < 0 && bank_switch_no[1]) begin
        sw_cyc = c;
      end
      if (sw_cyc >= 0 && bank_switch_ack_ni[1]) begin
        break;
      end
      @(negedge clk_i);
    end
    if (sw_cyc < 0 || !bank_switch_ack_ni[1]) begin
      fail_now("bank 1 never reached power off");
    end
    if (iso_cyc < 0 || iso_cyc >= sw_cyc) begin
      fail_now("bank 1 switch opened before isolation");
    end
    bus_read(ao_addr(mcu_cfg_pkg::AO_PWR_STATUS), rdata);
    check_banks("AO_PWR_STATUS", rdata[NB-1:0], b1_off);
    check_banks("bank_iso_no", bank_iso_no, b1_off);
    check_banks("bank_switch_no", bank_switch_no, ~b1_off);
    bus_write(ram_addr(0, 7), w0);
    bus_read(ram_addr(0, 7), rdata);
    check_word("bus_rdata_o bank 0 while bank 1 off", rdata, w0);
    // the write below lands while bank 1 still wakes up
    bus_write(ao_addr(mcu_cfg_pkg::AO_PWR_REQ), DW'(all_on));
    bus_access(1'b1, ram_addr(1, 5), w1, rdata, stalls);
    if (stalls == 0) begin
      fail_now("bank 1 granted a request before it was powered on");
    end
    bus_read(ao_addr(mcu_cfg_pkg::AO_PWR_STATUS), rdata);
    check_banks("AO_PWR_STATUS", rdata[NB-1:0], all_on);
    bus_read(ram_addr(1, 5), rdata);
    check_word("bus_rdata_o bank 1 after power up", rdata, w1);
  endtask

  task automatic test_exit();
    logic [DW-1:0] w;
    logic [DW-1:0] rdata;
    w = $urandom;
    check_flag("exit_valid_o", exit_valid_o, 1'b0);
    bus_write(ao_addr(mcu_cfg_pkg::AO_EXIT), w);
    check_flag("exit_valid_o", exit_valid_o, 1'b1);
    check_word("exit_value_o", exit_value_o, w);
    bus_read(ao_addr(mcu_cfg_pkg::AO_EXIT), rdata);
    check_word("AO_EXIT", rdata, w);
  endtask

  initial begin
    void'($urandom(SEED));
    repeat (2) @(posedge clk_i);
    arst_n_i <= 1'b1;
    test_reset_state();
    test_ram();
    test_unmapped();
    test_gpio();
    test_irq();
    test_power();
    test_exit();
    @(negedge clk_i);
    if (uut.chk.fail_count == 0) begin
      $display("Verification passed");
      $finish;
    end else begin
      $display("%0d assertion failures reported by the checker", uut.chk.fail_count);
      $display("Verification failed");
      $fatal(1, "assertion failures");
    end
  end

endmodule

`default_nettype wire

/* verilog.f */
hw/mcu_cfg_pkg.sv
hw/pwr_pkg.sv
hw/obi_if.sv
hw/system_bus.sv
hw/ram_bank.sv
hw/power_manager.sv
hw/ao_periph.sv
hw/mini_mcu_top.sv
testbench/mini_mcu_checker.sv
testbench/tb_mini_mcu.sv

/* run_sim.sh */
#!/bin/sh
# build the mini MCU testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=tb_mini_mcu

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_mini_mcu -f verilog.f -o "$BIN"
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Verification passed" "$LOG"; then
  exit 0
else
  echo "pass message not found in $LOG"
  exit 1
fi
